// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_flow_table
RTL_TOP    ?= flow_table_top
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_ARGS   ?= +verilator+error+limit+100
PASS_TEXT  ?= Result: PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/flow_bank.sv
`default_nettype none

module flow_bank (
    input  logic    clk,
    input  logic    rst,
    ft_port_if.bank port_a,
    ft_port_if.bank port_b
);
    import ft_pkg::*;

    for (genvar k = 0; k < FT_SUBTABLES; k++) begin : g_sub
        // Entry without its valid bit
        logic [$bits(fce_t)-2:0] mem [FT_DEPTH];
        logic [$bits(fce_t)-2:0] q_a;
        logic [$bits(fce_t)-2:0] q_b;
        logic [FT_DEPTH-1:0]     valid_q;
        logic                    v_a;
        logic                    v_b;

        always_ff @(posedge clk) begin
            if (port_b.wren[k]) begin
                mem[port_b.idx[k]] <= port_b.wdata[$bits(fce_t)-2:0];
            end
            // Old contents on a same-slot collision
            if (port_a.rden) begin
                q_a <= mem[port_a.idx[k]];
                v_a <= valid_q[port_a.idx[k]];
            end
            if (port_b.rden) begin
                q_b <= mem[port_b.idx[k]];
                v_b <= valid_q[port_b.idx[k]];
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                valid_q <= '0;
            end else if (port_b.wren[k]) begin
                valid_q[port_b.idx[k]] <= 1'b1;
            end
        end

        assign port_a.rdata[k] = {v_a, q_a};
        assign port_b.rdata[k] = {v_b, q_b};
    end

endmodule

`default_nettype wire

// File: hdl/flow_hash.sv
`default_nettype none

module flow_hash #(
    parameter type payload_t = logic
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              in_valid,
    input  ft_pkg::tuple_t    in_tuple,
    input  payload_t          in_payload,
    output logic              out_valid,
    output ft_pkg::tuple_t    out_tuple,
    output ft_pkg::idx_vec_t  out_idx,
    output payload_t          out_payload
);
    import ft_pkg::*;

    logic [FT_SUBTABLES-1:0][31:0] prod_q;
    logic                          valid_q;
    tuple_t                        tuple_q;
    payload_t                      payload_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            out_valid <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_valid;
            out_valid <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            // Stage 1, seeded products modulo 2^32
            for (int k = 0; k < FT_SUBTABLES; k++) begin
                prod_q[k] <= (in_tuple ^ FT_SEEDS[k]) * FT_HASH_MUL;
            end
            tuple_q <= in_tuple;
            payload_q <= in_payload;

            // Stage 2, top bits become the index
            for (int k = 0; k < FT_SUBTABLES; k++) begin
                out_idx[k] <= prod_q[k][31 -: FT_AWIDTH];
            end
            out_tuple <= tuple_q;
            out_payload <= payload_q;
        end
    end

endmodule

`default_nettype wire

// File: hdl/flow_lookup.sv
`default_nettype none

module flow_lookup (
    input  logic             clk,
    input  logic             rst,
    input  logic             h_valid,
    input  ft_pkg::tuple_t   h_tuple,
    input  ft_pkg::idx_vec_t h_idx,
    input  ft_pkg::meta_t    h_meta,
    output logic             stall,
    ft_port_if.user          port_a,
    output ft_pkg::tuple_t   out_tuple,
    output ft_pkg::tag_t     out_tag,
    output ft_pkg::qid_t     out_pkt_qid,
    output ft_pkg::qid_t     out_dsc_qid,
    output logic             out_valid,
    input  logic             out_ready
);
    import ft_pkg::*;

    logic     rd_q;
    logic     rdv_q;
    tuple_t   tuple1_q;
    tuple_t   tuple2_q;
    meta_t    meta1_q;
    meta_t    meta2_q;
    sub_vec_t hit;
    fce_t     hit_entry;

    // Downstream backpressure freezes every stage
    assign stall = !out_ready;

    assign port_a.rden = rd_q & !stall;
    assign port_a.wren = '0;
    assign port_a.wdata = '0;

    flow_match u_match (
        .tuple     (tuple2_q),
        .entries   (port_a.rdata),
        .hit       (hit),
        .empty     (),
        .hit_entry (hit_entry)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_q <= 1'b0;
            rdv_q <= 1'b0;
            out_valid <= 1'b0;
        end else if (!stall) begin
            rd_q <= h_valid;
            rdv_q <= rd_q;
            out_valid <= rdv_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (h_valid) begin
                port_a.idx <= h_idx;
                tuple1_q <= h_tuple;
                meta1_q <= h_meta;
            end
            // Lines up with the bank read data
            if (rd_q) begin
                tuple2_q <= tuple1_q;
                meta2_q <= meta1_q;
            end
            if (rdv_q) begin
                out_tuple <= tuple2_q;
                out_tag <= meta2_q.tag;
                if (hit != '0) begin
                    out_pkt_qid <= hit_entry.pkt_qid;
                    out_dsc_qid <= hit_entry.dsc_qid;
                end else begin
                    // All ones marks a drop
                    out_pkt_qid <= '1;
                    out_dsc_qid <= '1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/flow_match.sv
`default_nettype none

module flow_match (
    input  ft_pkg::tuple_t   tuple,
    input  ft_pkg::fce_t     entries [ft_pkg::FT_SUBTABLES],
    output ft_pkg::sub_vec_t hit,
    output ft_pkg::sub_vec_t empty,
    output ft_pkg::fce_t     hit_entry
);
    import ft_pkg::*;

    always_comb begin
        logic h;

        hit = '0;
        empty = '0;
        hit_entry = entries[0];
        // Walk down so the lowest hit wins
        for (int k = FT_SUBTABLES - 1; k >= 0; k--) begin
            h = entries[k].valid && (entries[k].tuple == tuple);
            hit[k] = h;
            empty[k] = !entries[k].valid;
            if (h) begin
                hit_entry = entries[k];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/flow_place_ctrl.sv
`default_nettype none

module flow_place_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             h_valid,
    input  ft_pkg::tuple_t   h_tuple,
    input  ft_pkg::idx_vec_t h_idx,
    input  ft_pkg::req_t     h_req,
    output logic             busy,
    ft_port_if.user          port_b,
    output logic             done,
    output logic             full
);
    import ft_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        DECIDE,
        WRITE
    } state_t;

    state_t   state;
    fce_t     entry_q;
    sub_vec_t hit;
    sub_vec_t empty;
    sub_vec_t hit_q;
    sub_vec_t empty_q;

    function automatic sub_vec_t lowest(input sub_vec_t v);
        return v & (~v + sub_vec_t'(1));
    endfunction

    flow_match u_match (
        .tuple     (entry_q.tuple),
        .entries   (port_b.rdata),
        .hit       (hit),
        .empty     (empty),
        .hit_entry ()
    );

    // Bank samples the entry on the edge after WRITE
    assign port_b.wdata = entry_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            busy <= 1'b0;
            done <= 1'b0;
            full <= 1'b0;
            port_b.rden <= 1'b0;
            port_b.wren <= '0;
        end else begin
            done <= 1'b0;
            full <= 1'b0;
            port_b.rden <= 1'b0;
            port_b.wren <= '0;
            case (state)
                IDLE: begin
                    if (h_valid) begin
                        port_b.rden <= 1'b1;
                        busy <= 1'b1;
                        state <= LOOKUP;
                    end
                end
                LOOKUP: state <= DECIDE;
                DECIDE: state <= WRITE;
                WRITE: begin
                    // Update first, then insert, else report full
                    if (hit_q != '0) begin
                        port_b.wren <= lowest(hit_q);
                    end else begin
                        port_b.wren <= lowest(empty_q);
                    end
                    full <= (hit_q == '0) && (empty_q == '0);
                    done <= 1'b1;
                    busy <= 1'b0;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && h_valid) begin
            port_b.idx <= h_idx;
            entry_q <= '{valid: 1'b1, tuple: h_tuple, pkt_qid: h_req.pkt_qid,
                         dsc_qid: h_req.dsc_qid};
        end
        if (state == DECIDE) begin
            hit_q <= hit;
            empty_q <= empty;
        end
    end

endmodule

`default_nettype wire

// File: hdl/flow_table_top.sv
`default_nettype none

module flow_table_top (
    input  logic           clk,
    input  logic           rst,
    input  ft_pkg::tuple_t in_meta_tuple,
    input  ft_pkg::tag_t   in_meta_tag,
    input  logic           in_meta_valid,
    output logic           in_meta_ready,
    output ft_pkg::tuple_t out_meta_tuple,
    output ft_pkg::tag_t   out_meta_tag,
    output ft_pkg::qid_t   out_meta_pkt_qid,
    output ft_pkg::qid_t   out_meta_dsc_qid,
    output logic           out_meta_valid,
    input  logic           out_meta_ready,
    input  ft_pkg::tuple_t in_control_tuple,
    input  ft_pkg::qid_t   in_control_pkt_qid,
    input  ft_pkg::qid_t   in_control_dsc_qid,
    input  logic           in_control_valid,
    output logic           in_control_ready,
    output logic           out_control_done,
    output logic           out_control_full
);
    import ft_pkg::*;

    logic     lk_stall;
    logic     lk_valid;
    tuple_t   lk_tuple;
    idx_vec_t lk_idx;
    meta_t    lk_meta;
    logic     pl_busy;
    logic     pl_valid;
    tuple_t   pl_tuple;
    idx_vec_t pl_idx;
    req_t     pl_req;

    ft_port_if port_a ();
    ft_port_if port_b ();

    assign in_meta_ready = !lk_stall;
    assign in_control_ready = !pl_busy;

    flow_hash #(.payload_t(meta_t)) u_lookup_hash (
        .clk (clk), .rst (rst), .stall (lk_stall),
        .in_valid (in_meta_valid), .in_tuple (in_meta_tuple), .in_payload (in_meta_tag),
        .out_valid (lk_valid), .out_tuple (lk_tuple), .out_idx (lk_idx),
        .out_payload (lk_meta)
    );

    flow_hash #(.payload_t(req_t)) u_place_hash (
        .clk (clk), .rst (rst), .stall (pl_busy),
        .in_valid (in_control_valid), .in_tuple (in_control_tuple),
        .in_payload ({in_control_pkt_qid, in_control_dsc_qid}),
        .out_valid (pl_valid), .out_tuple (pl_tuple), .out_idx (pl_idx),
        .out_payload (pl_req)
    );

    flow_lookup u_lookup (
        .clk (clk), .rst (rst), .h_valid (lk_valid), .h_tuple (lk_tuple),
        .h_idx (lk_idx), .h_meta (lk_meta), .stall (lk_stall), .port_a (port_a.user),
        .out_tuple (out_meta_tuple), .out_tag (out_meta_tag),
        .out_pkt_qid (out_meta_pkt_qid), .out_dsc_qid (out_meta_dsc_qid),
        .out_valid (out_meta_valid), .out_ready (out_meta_ready)
    );

    flow_place_ctrl u_place_ctrl (
        .clk (clk), .rst (rst), .h_valid (pl_valid), .h_tuple (pl_tuple),
        .h_idx (pl_idx), .h_req (pl_req), .busy (pl_busy), .port_b (port_b.user),
        .done (out_control_done), .full (out_control_full)
    );

    flow_bank u_bank (
        .clk (clk), .rst (rst), .port_a (port_a.bank), .port_b (port_b.bank)
    );

endmodule

`default_nettype wire

// File: hdl/ft_pkg.sv
`default_nettype none

package ft_pkg;

    localparam int FT_SUBTABLES = 4;
    localparam int FT_AWIDTH = 4;
    localparam int FT_DEPTH = 16;

    // Seed k sits in word k
    localparam logic [FT_SUBTABLES-1:0][31:0] FT_SEEDS = {
        32'd3,
        32'd2,
        32'd1,
        32'd0
    };

    localparam logic [31:0] FT_HASH_MUL = 32'h9E3779B1;

    // Acceptance edge through output register, no stall
    localparam int FT_LOOKUP_LAT = 5;

    typedef logic [31:0] tuple_t;
    typedef logic [7:0] qid_t;
    typedef logic [7:0] tag_t;

    // Valid must stay the top bit, the bank stores the rest
    typedef struct packed {
        logic   valid;
        tuple_t tuple;
        qid_t   pkt_qid;
        qid_t   dsc_qid;
    } fce_t;

    typedef struct packed {
        tag_t tag;
    } meta_t;

    typedef struct packed {
        qid_t pkt_qid;
        qid_t dsc_qid;
    } req_t;

    typedef logic [FT_SUBTABLES-1:0][FT_AWIDTH-1:0] idx_vec_t;
    typedef logic [FT_SUBTABLES-1:0] sub_vec_t;

endpackage

`default_nettype wire

// File: hdl/ft_port_if.sv
`default_nettype none

interface ft_port_if;
    import ft_pkg::*;

    idx_vec_t idx;
    logic     rden;
    sub_vec_t wren;
    fce_t     wdata;
    // One read entry per subtable
    fce_t     rdata [FT_SUBTABLES];

    modport user (
        output idx, rden, wren, wdata,
        input  rdata
    );

    modport bank (
        input  idx, rden, wren, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: project.f
hdl/ft_pkg.sv
hdl/ft_port_if.sv
hdl/flow_hash.sv
hdl/flow_bank.sv
hdl/flow_match.sv
hdl/flow_lookup.sv
hdl/flow_place_ctrl.sv
hdl/flow_table_top.sv
sim/flow_table_assert.sv
sim/tb_flow_table.sv

// File: sim/flow_table_assert.sv
`default_nettype none

module flow_table_assert (
    input logic           clk,
    input logic           rst,
    input logic           in_control_ready,
    input logic           out_control_done,
    input logic           out_control_full,
    input logic           out_meta_valid,
    input logic           out_meta_ready,
    input ft_pkg::tuple_t out_meta_tuple,
    input ft_pkg::tag_t   out_meta_tag,
    input ft_pkg::qid_t   out_meta_pkt_qid,
    input ft_pkg::qid_t   out_meta_dsc_qid
);
    int assert_errors = 0;

    full_needs_done: assert property (@(posedge clk) disable iff (rst)
        out_control_full |-> out_control_done)
        else begin
            assert_errors++;
            $error("out_control_full high without out_control_done");
        end

    // Ready comes back only with the done pulse
    ready_returns_with_done: assert property (@(posedge clk) disable iff (rst)
        $rose(in_control_ready) |-> out_control_done)
        else begin
            assert_errors++;
            $error("in_control_ready rose without out_control_done");
        end

    done_with_ready: assert property (@(posedge clk) disable iff (rst)
        out_control_done |-> in_control_ready)
        else begin
            assert_errors++;
            $error("out_control_done while in_control_ready is low");
        end

    meta_holds_on_stall: assert property (@(posedge clk) disable iff (rst)
        out_meta_valid && !out_meta_ready |=> out_meta_valid
            && $stable(out_meta_tuple) && $stable(out_meta_tag)
            && $stable(out_meta_pkt_qid) && $stable(out_meta_dsc_qid))
        else begin
            assert_errors++;
            $error("lookup output changed while stalled");
        end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !out_meta_valid && !out_control_done && !out_control_full)
        else begin
            assert_errors++;
            $error("output active in the cycle after reset");
        end

endmodule

bind flow_table_top flow_table_assert u_flow_table_assert (
    .clk (clk), .rst (rst),
    .in_control_ready (in_control_ready), .out_control_done (out_control_done),
    .out_control_full (out_control_full), .out_meta_valid (out_meta_valid),
    .out_meta_ready (out_meta_ready), .out_meta_tuple (out_meta_tuple),
    .out_meta_tag (out_meta_tag), .out_meta_pkt_qid (out_meta_pkt_qid),
    .out_meta_dsc_qid (out_meta_dsc_qid)
);

`default_nettype wire

// File: sim/tb_flow_table.sv
`default_nettype none

module tb_flow_table;
    import ft_pkg::*;

    localparam int POOL_SIZE = 100;

    typedef struct packed {
        tuple_t      tuple;
        tag_t        tag;
        qid_t        pkt;
        qid_t        dsc;
        logic [31:0] cyc;
        logic        timed;
    } exp_t;

    logic   clk;
    logic   rst;
    tuple_t in_meta_tuple;
    tag_t   in_meta_tag;
    logic   in_meta_valid;
    logic   in_meta_ready;
    tuple_t out_meta_tuple;
    tag_t   out_meta_tag;
    qid_t   out_meta_pkt_qid;
    qid_t   out_meta_dsc_qid;
    logic   out_meta_valid;
    logic   out_meta_ready;
    tuple_t in_control_tuple;
    qid_t   in_control_pkt_qid;
    qid_t   in_control_dsc_qid;
    logic   in_control_valid;
    logic   in_control_ready;
    logic   out_control_done;
    logic   out_control_full;

    // Reference table
    logic   m_valid [FT_SUBTABLES][FT_DEPTH];
    tuple_t m_tuple [FT_SUBTABLES][FT_DEPTH];
    qid_t   m_pkt   [FT_SUBTABLES][FT_DEPTH];
    qid_t   m_dsc   [FT_SUBTABLES][FT_DEPTH];

    tuple_t      pool [POOL_SIZE];
    exp_t        exp_q [$];
    logic [31:0] lcg_state = 32'd30;
    logic [31:0] cyc = '0;
    int          n_update = 0;
    int          n_full = 0;
    tuple_t      full_tuple;

    flow_table_top u_flow_table_top (
        .clk (clk), .rst (rst),
        .in_meta_tuple (in_meta_tuple), .in_meta_tag (in_meta_tag),
        .in_meta_valid (in_meta_valid), .in_meta_ready (in_meta_ready),
        .out_meta_tuple (out_meta_tuple), .out_meta_tag (out_meta_tag),
        .out_meta_pkt_qid (out_meta_pkt_qid), .out_meta_dsc_qid (out_meta_dsc_qid),
        .out_meta_valid (out_meta_valid), .out_meta_ready (out_meta_ready),
        .in_control_tuple (in_control_tuple), .in_control_pkt_qid (in_control_pkt_qid),
        .in_control_dsc_qid (in_control_dsc_qid), .in_control_valid (in_control_valid),
        .in_control_ready (in_control_ready), .out_control_done (out_control_done),
        .out_control_full (out_control_full)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    // Seed of subtable k is k itself
    function automatic int hash_index(input tuple_t t, input int k);
        logic [31:0] prod;

        prod = (t ^ 32'(k)) * 32'h9E3779B1;
        return int'(prod >> (32 - FT_AWIDTH));
    endfunction

    function automatic logic [15:0] model_lookup(input tuple_t t);
        int s;

        for (int k = 0; k < FT_SUBTABLES; k++) begin
            s = hash_index(t, k);
            if (m_valid[k][s] && m_tuple[k][s] == t) begin
                return {m_pkt[k][s], m_dsc[k][s]};
            end
        end
        return 16'hffff;
    endfunction

    task automatic model_place(input tuple_t t, input qid_t pq, input qid_t dq,
                               output logic full);
        int slot [FT_SUBTABLES];
        int hit_k;
        int empty_k;
        int k_sel;

        hit_k = -1;
        empty_k = -1;
        for (int k = FT_SUBTABLES - 1; k >= 0; k--) begin
            slot[k] = hash_index(t, k);
            if (m_valid[k][slot[k]] && m_tuple[k][slot[k]] == t) begin
                hit_k = k;
            end
            if (!m_valid[k][slot[k]]) begin
                empty_k = k;
            end
        end
        // Update wins over insert
        k_sel = (hit_k >= 0) ? hit_k : empty_k;
        full = (k_sel < 0);
        if (full) begin
            n_full++;
            full_tuple = t;
        end else begin
            if (hit_k >= 0) begin
                n_update++;
            end
            m_valid[k_sel][slot[k_sel]] = 1'b1;
            m_tuple[k_sel][slot[k_sel]] = t;
            m_pkt[k_sel][slot[k_sel]] = pq;
            m_dsc[k_sel][slot[k_sel]] = dq;
        end
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, want);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // Output side, pre-edge values at each rising edge
    always @(posedge clk) begin
        exp_t e;

        if (!rst && out_meta_valid && out_meta_ready) begin
            if (exp_q.size() == 0) begin
                $display("Lookup result at %0t with no packet outstanding", $time);
                $display("Result: FAILED");
                $fatal(1);
            end else begin
                e = exp_q.pop_front();
                check_eq("out_meta_tuple", out_meta_tuple, e.tuple);
                check_eq("out_meta_tag", 32'(out_meta_tag), 32'(e.tag));
                check_eq("out_meta_pkt_qid", 32'(out_meta_pkt_qid), 32'(e.pkt));
                check_eq("out_meta_dsc_qid", 32'(out_meta_dsc_qid), 32'(e.dsc));
                if (e.timed) begin
                    check_eq("lookup latency", cyc - e.cyc, 32'(FT_LOOKUP_LAT));
                end
            end
        end
    end

    task automatic send_control(input tuple_t t, input qid_t pq, input qid_t dq);
        logic want_full;
        int   waited;

        model_place(t, pq, dq, want_full);
        @(posedge clk);
        in_control_valid <= 1'b1;
        in_control_tuple <= t;
        in_control_pkt_qid <= pq;
        in_control_dsc_qid <= dq;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 50) begin
                fail_timeout("the control request to be accepted");
            end
        end while (!in_control_ready);
        in_control_valid <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 50) begin
                fail_timeout("the control done pulse");
            end
        end while (!out_control_done);
        check_eq("out_control_full", 32'(out_control_full), 32'(want_full));
    endtask

    task automatic run_lookups(input int n, input logic gaps, input tuple_t first);
        int          issued;
        int          accepted;
        int          waited;
        tuple_t      t;
        logic [15:0] q;
        exp_t        e;

        issued = 0;
        accepted = 0;
        waited = 0;
        while (accepted < n) begin
            @(posedge clk);
            waited++;
            if (waited > 20 * n + 100) begin
                fail_timeout("lookup packets to be accepted");
            end
            if (in_meta_valid && in_meta_ready) begin
                q = model_lookup(in_meta_tuple);
                e.tuple = in_meta_tuple;
                e.tag = in_meta_tag;
                e.pkt = q[15:8];
                e.dsc = q[7:0];
                e.cyc = cyc;
                e.timed = !gaps;
                exp_q.push_back(e);
                accepted++;
            end
            // Data holds while the packet waits
            if (!in_meta_valid || in_meta_ready) begin
                if (issued < n && (next_random() % 4) != 0) begin
                    if (issued == 0) begin
                        t = first;
                    end else if ((next_random() % 5) == 0) begin
                        t = next_random();
                    end else begin
                        t = pool[next_random() % POOL_SIZE];
                    end
                    in_meta_valid <= 1'b1;
                    in_meta_tuple <= t;
                    in_meta_tag <= tag_t'(next_random());
                    issued++;
                end else begin
                    in_meta_valid <= 1'b0;
                end
            end
            out_meta_ready <= gaps ? ((next_random() % 3) != 0) : 1'b1;
        end
        in_meta_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (exp_q.size() != 0) begin
            @(posedge clk);
            out_meta_ready <= gaps ? ((next_random() % 3) != 0) : 1'b1;
            @(negedge clk);
            waited++;
            if (waited > 200) begin
                fail_timeout("lookup results to drain");
            end
        end
        @(posedge clk);
        out_meta_ready <= 1'b1;
    endtask

    initial begin
        rst = 1'b1;
        in_meta_tuple = '0;
        in_meta_tag = '0;
        in_meta_valid = 1'b0;
        out_meta_ready = 1'b1;
        in_control_tuple = '0;
        in_control_pkt_qid = '0;
        in_control_dsc_qid = '0;
        in_control_valid = 1'b0;
        for (int k = 0; k < FT_SUBTABLES; k++) begin
            for (int i = 0; i < FT_DEPTH; i++) begin
                m_valid[k][i] = 1'b0;
            end
        end
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = next_random();
        end
        full_tuple = pool[1];

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_eq("out_meta_valid", 32'(out_meta_valid), 32'd0);
        check_eq("out_control_done", 32'(out_control_done), 32'd0);
        check_eq("in_control_ready", 32'(in_control_ready), 32'd1);

        // Empty table, every lookup misses
        run_lookups(24, 1'b0, pool[0]);
        // Insert, then update in place
        send_control(pool[0], 8'h12, 8'h34);
        run_lookups(4, 1'b0, pool[0]);
        send_control(pool[0], 8'h56, 8'h78);
        run_lookups(4, 1'b0, pool[0]);

        // More distinct tuples than slots, so full reports must appear
        for (int phase = 0; phase < 3; phase++) begin
            repeat (90) begin
                send_control(pool[next_random() % POOL_SIZE], qid_t'(next_random()),
                             qid_t'(next_random()));
            end
            run_lookups(60, 1'b1, full_tuple);
            run_lookups(20, 1'b0, full_tuple);
        end

        if (n_update == 0 || n_full == 0 ||
            u_flow_table_top.u_flow_table_assert.assert_errors != 0) begin
            $display("Missing cases or assertion failures: updates=%0d full=%0d asserts=%0d",
                     n_update, n_full, u_flow_table_top.u_flow_table_assert.assert_errors);
            $display("Result: FAILED");
            $fatal(1);
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
